// ==== flist.f ====
verilog/sdcmd_cfg_pkg.sv
verilog/sdcmd_err_pkg.sv
verilog/sdcmd_frame_if.sv
verilog/sdcmd_req_queue.sv
verilog/sdcmd_timer.sv
verilog/sdcmd_shifter.sv
verilog/sdcmd_fsm.sv
verilog/sdcmd_err.sv
verilog/sdcmd_top.sv
tb/sdcmd_checker.sv
tb/sdcmd_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the command path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module sdcmd_tb -o sdcmd_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sdcmd_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation PASSED" sim.log; then
    exit 0
fi
exit 1

// ==== tb/sdcmd_tb.sv ====
`timescale 1ns/1ps

module sdcmd_tb;

    localparam int FB     = sdcmd_cfg_pkg::FRAME_BITS;
    localparam int N_CMDS = 15;
    localparam int LIMIT  = (N_CMDS + 2) * (2 * FB + sdcmd_cfg_pkg::NCR_MAX + 16)
                            * sdcmd_cfg_pkg::CLK_DIV;

    logic        i_clk;
    logic        i_nrst;
    logic        i_req_valid;
    logic [5:0]  i_req_index;
    logic [31:0] i_req_arg;
    logic        o_credit;
    logic        o_resp_valid;
    logic [5:0]  o_resp_index;
    logic [31:0] o_resp_arg;
    logic [3:0]  o_err_code;
    logic        o_err_pending;
    logic        i_err_clear;
    logic        o_sd_clk;
    logic        o_cmd;
    logic        o_cmd_oe;
    logic        i_cmd;

    logic [15:0] lfsr;
    logic [37:0] expected [$];
    int          sent;
    int          returned;
    int          cycles;
    int          resp_errors;
    int          code_errors;
    int          card_errors;

    sdcmd_top dut_i (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // Galois LFSR, one step yields one stimulus bit
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // CRC7 over the first 40 frame bits, MSB first, polynomial x^7 + x^3 + 1
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int k = 39; k >= 0; k--) begin
            fb = bits[k] ^ c[6];
            c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    task automatic random_arg(output logic [31:0] arg);
        for (int k = 0; k < 32; k++) begin
            arg[k] = lfsr[0];
            lfsr   = lfsr_step(lfsr);
        end
    endtask

    // Waits for a credit, then queues one command for a single cycle
    task automatic send_cmd(input logic [5:0] idx, input logic want_resp);
        logic [31:0] arg;
        while (sent - returned >= sdcmd_cfg_pkg::REQ_DEPTH) begin
            @(negedge i_clk);
        end
        random_arg(arg);
        i_req_valid = 1'b1;
        i_req_index = idx;
        i_req_arg   = arg;
        sent++;
        if (want_resp) begin
            expected.push_back({idx, ~arg});
        end
        @(negedge i_clk);
        i_req_valid = 1'b0;
    endtask

    // Last command of each group answers normally, so this marks the group done
    task automatic wait_done();
        while (expected.size() != 0 || sent != returned) begin
            @(negedge i_clk);
        end
        @(negedge i_clk);
    endtask

    // Raises clear for exactly the cycle in which the fsm hands an error to the latch
    task automatic clear_with_error();
        while (!dut_i.err_valid) begin
            @(negedge i_clk);
        end
        i_err_clear = 1'b1;
        @(negedge i_clk);
        i_err_clear = 1'b0;
    endtask

    task automatic check_code(input logic [3:0] want, input string what);
        assert (o_err_code == want) else begin
            code_errors++;
            $display("Fail %0t: error code %0d, expected %0d %s", $time, o_err_code, want, what);
        end
    endtask

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (o_credit) begin
            returned <= returned + 1;
        end
        if (o_resp_valid) begin
            assert (expected.size() != 0) else begin
                resp_errors++;
                $display("Fail %0t: response pulse with none outstanding", $time);
            end
            if (expected.size() != 0) begin
                assert ({o_resp_index, o_resp_arg} == expected[0]) else begin
                    resp_errors++;
                    $display("Fail %0t: response %0d/%h, expected %0d/%h", $time,
                             o_resp_index, o_resp_arg, expected[0][37:32], expected[0][31:0]);
                end
                void'(expected.pop_front());
            end
        end
        if (cycles >= LIMIT) begin
            $display("Run stopped: cycle limit %0d reached before all commands finished", LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Card model samples on rising SD clock and answers on falling SD clock
    initial begin
        logic [FB-1:0] cmd;
        logic [FB-1:0] rsp;
        i_cmd = 1'b1;
        forever begin
            @(posedge o_sd_clk);
            if (o_cmd_oe && !o_cmd) begin
                cmd[FB-1] = 1'b0;
                for (int k = FB - 2; k >= 0; k--) begin
                    @(posedge o_sd_clk);
                    cmd[k] = o_cmd;
                end
                assert (cmd[7:1] == crc7_of(cmd[47:8]) && cmd[0] && cmd[46]) else begin
                    card_errors++;
                    $display("Fail %0t: command frame %h has a bad CRC or framing", $time, cmd);
                end
                if (cmd[45:40] != 6'd5) begin
                    rsp = {2'b00, (cmd[45:40] == 6'd9) ? 6'd10 : cmd[45:40], ~cmd[39:8], 8'h01};
                    rsp[7:1] = crc7_of(rsp[47:8]);
                    if (cmd[45:40] == 6'd7) begin
                        rsp[1] = ~rsp[1];
                    end
                    repeat (8) @(negedge o_sd_clk);
                    for (int k = FB - 1; k >= 0; k--) begin
                        @(negedge o_sd_clk);
                        @(negedge i_clk);
                        i_cmd = rsp[k];
                    end
                    @(negedge o_sd_clk);
                    @(negedge i_clk);
                    i_cmd = 1'b1;
                end
            end
        end
    end

    initial begin
        i_nrst      = 1'b0;
        i_req_valid = 1'b0;
        i_req_index = '0;
        i_req_arg   = '0;
        i_err_clear = 1'b0;
        lfsr        = 16'd1249;
        sent        = 0;
        returned    = 0;
        cycles      = 0;
        resp_errors = 0;
        code_errors = 0;
        card_errors = 0;
        repeat (16) @(negedge i_clk);
        i_nrst = 1'b1;
        @(negedge i_clk);
        // Normal commands issued as fast as credits allow
        send_cmd(6'd17, 1'b1);
        send_cmd(6'd2, 1'b1);
        send_cmd(6'd3, 1'b1);
        send_cmd(6'd55, 1'b1);
        send_cmd(6'd8, 1'b1);
        send_cmd(6'd41, 1'b1);
        wait_done();
        check_code(sdcmd_err_pkg::ERR_NONE, "after normal commands");
        // Silent card, then a command that must still complete
        send_cmd(6'd5, 1'b0);
        send_cmd(6'd8, 1'b1);
        wait_done();
        check_code(sdcmd_err_pkg::ERR_TIMEOUT, "after silent card");
        i_err_clear = 1'b1;
        @(negedge i_clk);
        i_err_clear = 1'b0;
        // CRC error first, the index error after it must not replace it
        send_cmd(6'd7, 1'b0);
        send_cmd(6'd9, 1'b0);
        send_cmd(6'd12, 1'b1);
        wait_done();
        check_code(sdcmd_err_pkg::ERR_CRC, "after CRC then index error");
        i_err_clear = 1'b1;
        @(negedge i_clk);
        i_err_clear = 1'b0;
        @(negedge i_clk);
        check_code(sdcmd_err_pkg::ERR_NONE, "after clear");
        send_cmd(6'd9, 1'b0);
        send_cmd(6'd3, 1'b1);
        wait_done();
        check_code(sdcmd_err_pkg::ERR_INDEX, "after wrong response index");
        i_err_clear = 1'b1;
        @(negedge i_clk);
        i_err_clear = 1'b0;
        // Clear in the very cycle of the index error wins over it
        send_cmd(6'd9, 1'b0);
        send_cmd(6'd4, 1'b1);
        clear_with_error();
        wait_done();
        check_code(sdcmd_err_pkg::ERR_NONE, "with clear during an error");
        $display("Errors: response %0d, error code %0d, card %0d, assertion %0d",
                 resp_errors, code_errors, card_errors, dut_i.chk_i.fail_count);
        if (resp_errors + code_errors + card_errors + dut_i.chk_i.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/sdcmd_checker.sv ====
`timescale 1ns/1ps

module sdcmd_checker (
    input logic        i_clk,
    input logic        i_nrst,
    input logic        i_req_valid,
    input logic        o_credit,
    input logic        o_resp_valid,
    input logic [3:0]  o_err_code,
    input logic        o_err_pending,
    input logic        i_err_clear,
    input logic        o_sd_clk,
    input logic        o_cmd,
    input logic        o_cmd_oe
);

    // Requests accepted by the queue whose credit has not come back yet
    logic [2:0] outstanding;
    // Number of assertion failures so far
    int         fail_count = 0;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + {2'b00, i_req_valid} - {2'b00, o_credit};
        end
    end

    // First clock after reset release still shows the reset values
    reset_idle: assert property (@(posedge i_clk) $rose(i_nrst) |->
        (!o_credit && !o_resp_valid && !o_cmd_oe && !o_err_pending && o_cmd && !o_sd_clk))
        else begin
            $error("Outputs not idle after reset");
            fail_count = fail_count + 1;
        end

    pending_match: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_err_pending == (o_err_code != 4'd0))
        else begin
            $error("Error pending flag does not match the stored code");
            fail_count = fail_count + 1;
        end

    credit_limit: assert property (@(posedge i_clk) disable iff (!i_nrst)
        outstanding <= 3'(sdcmd_cfg_pkg::REQ_DEPTH))
        else begin
            $error("More outstanding requests than queue entries");
            fail_count = fail_count + 1;
        end

    // A stored error only goes away through clear
    code_sticky: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (o_err_code != 4'd0 && !i_err_clear) |=> $stable(o_err_code))
        else begin
            $error("Stored error code changed without a clear");
            fail_count = fail_count + 1;
        end

endmodule

bind sdcmd_top sdcmd_checker chk_i (
    .i_clk(i_clk), .i_nrst(i_nrst), .i_req_valid(i_req_valid), .o_credit(o_credit),
    .o_resp_valid(o_resp_valid), .o_err_code(o_err_code), .o_err_pending(o_err_pending),
    .i_err_clear(i_err_clear), .o_sd_clk(o_sd_clk), .o_cmd(o_cmd), .o_cmd_oe(o_cmd_oe)
);

// ==== verilog/sdcmd_top.sv ====
`timescale 1ns/1ps

module sdcmd_top (
    input  logic        i_clk,
    input  logic        i_nrst,
    // Host request port, governed by credits
    input  logic        i_req_valid,
    input  logic [5:0]  i_req_index,
    input  logic [31:0] i_req_arg,
    output logic        o_credit,
    // Response port, a single-cycle pulse
    output logic        o_resp_valid,
    output logic [5:0]  o_resp_index,
    output logic [31:0] o_resp_arg,
    // Sticky error register
    output logic [3:0]  o_err_code,
    output logic        o_err_pending,
    input  logic        i_err_clear,
    // SD card pins
    output logic        o_sd_clk,
    output logic        o_cmd,
    output logic        o_cmd_oe,
    input  logic        i_cmd
);

    sdcmd_cfg_pkg::sdcmd_req_t req_in;
    sdcmd_cfg_pkg::sdcmd_req_t req_head;
    logic       req_nonempty;
    logic       req_pop;
    logic       wd_start;
    logic       wd_expired;
    logic       tick_fall;
    logic       tick_rise;
    logic       err_valid;
    logic [3:0] err_code;

    sdcmd_frame_if frame_i ();

    assign req_in.index = i_req_index;
    assign req_in.arg   = i_req_arg;

    sdcmd_req_queue queue_i (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_push(i_req_valid), .i_req(req_in),
        .i_pop(req_pop), .o_req(req_head), .o_nonempty(req_nonempty), .o_credit(o_credit)
    );

    sdcmd_timer timer_i (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_wd_start(wd_start), .o_sd_clk(o_sd_clk),
        .o_tick_fall(tick_fall), .o_tick_rise(tick_rise), .o_wd_expired(wd_expired)
    );

    sdcmd_shifter shifter_i (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_tick_fall(tick_fall), .i_tick_rise(tick_rise),
        .i_cmd(i_cmd), .o_cmd(o_cmd), .o_cmd_oe(o_cmd_oe), .frame(frame_i.shifter)
    );

    sdcmd_fsm fsm_i (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_nonempty(req_nonempty), .i_req(req_head),
        .o_pop(req_pop), .o_wd_start(wd_start), .i_wd_expired(wd_expired),
        .frame(frame_i.fsm), .o_err_valid(err_valid), .o_err_code(err_code),
        .o_resp_valid(o_resp_valid), .o_resp_index(o_resp_index), .o_resp_arg(o_resp_arg)
    );

    sdcmd_err err_i (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_err_valid(err_valid), .i_err_code(err_code),
        .i_err_clear(i_err_clear), .o_err_code(o_err_code), .o_err_pending(o_err_pending)
    );

endmodule

// ==== verilog/sdcmd_err.sv ====
`timescale 1ns/1ps

module sdcmd_err (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_err_valid,
    input  logic [3:0] i_err_code,
    input  logic       i_err_clear,
    output logic [3:0] o_err_code,
    output logic       o_err_pending
);

    sdcmd_err_pkg::sdcmd_err_regs_t r;
    sdcmd_err_pkg::sdcmd_err_regs_t rin;

    // Only the first error is kept, and clear beats a new error
    always_comb begin
        rin = r;
        if (i_err_clear) begin
            rin.code = sdcmd_err_pkg::ERR_NONE;
        end else if (i_err_valid && r.code == sdcmd_err_pkg::ERR_NONE
                     && i_err_code != sdcmd_err_pkg::ERR_NONE) begin
            rin.code = i_err_code;
        end
    end

    assign o_err_code    = r.code;
    assign o_err_pending = |r.code;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r <= sdcmd_err_pkg::err_regs_reset;
        end else begin
            r <= rin;
        end
    end

endmodule

// ==== verilog/sdcmd_fsm.sv ====
`timescale 1ns/1ps

module sdcmd_fsm (
    input  logic                      i_clk,
    input  logic                      i_nrst,
    input  logic                      i_nonempty,
    input  sdcmd_cfg_pkg::sdcmd_req_t i_req,
    output logic                      o_pop,
    output logic                      o_wd_start,
    input  logic                      i_wd_expired,
    sdcmd_frame_if.fsm                frame,
    output logic                      o_err_valid,
    output logic [3:0]                o_err_code,
    output logic                      o_resp_valid,
    output logic [5:0]                o_resp_index,
    output logic [31:0]               o_resp_arg
);

    typedef enum logic [1:0] {IDLE, SEND, WAIT_RESP, RECV} state_t;

    state_t     state;
    state_t     state_next;
    logic [5:0] sent_index;
    logic [3:0] rx_err;
    logic       timeout;
    logic       rx_end;

    // Response checks in priority order, CRC first and index last
    always_comb begin
        if (!frame.rx_crc_ok) begin
            rx_err = sdcmd_err_pkg::ERR_CRC;
        end else if (!frame.rx_end_ok) begin
            rx_err = sdcmd_err_pkg::ERR_END_BIT;
        end else if (frame.rx_index != sent_index) begin
            rx_err = sdcmd_err_pkg::ERR_INDEX;
        end else begin
            rx_err = sdcmd_err_pkg::ERR_NONE;
        end
    end

    // Popping the head and starting the frame happen in the same cycle
    assign o_pop          = (state == IDLE) && i_nonempty;
    assign frame.tx_start = o_pop;
    assign frame.tx_index = i_req.index;
    assign frame.tx_arg   = i_req.arg;
    assign frame.rx_arm   = (state == WAIT_RESP);
    assign o_wd_start     = (state == SEND) && frame.tx_done;

    // A start bit in the expiry cycle still counts as a response
    assign timeout = (state == WAIT_RESP) && !frame.rx_started && i_wd_expired;
    assign rx_end  = (state == RECV) && frame.rx_done;

    assign o_err_valid  = timeout || (rx_end && (rx_err != sdcmd_err_pkg::ERR_NONE));
    assign o_err_code   = timeout ? sdcmd_err_pkg::ERR_TIMEOUT : rx_err;
    assign o_resp_valid = rx_end && (rx_err == sdcmd_err_pkg::ERR_NONE);
    assign o_resp_index = frame.rx_index;
    assign o_resp_arg   = frame.rx_arg;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (i_nonempty) begin
                    state_next = SEND;
                end
            end
            SEND: begin
                if (frame.tx_done) begin
                    state_next = WAIT_RESP;
                end
            end
            WAIT_RESP: begin
                if (frame.rx_started) begin
                    state_next = RECV;
                end else if (i_wd_expired) begin
                    state_next = IDLE;
                end
            end
            RECV: begin
                // The watchdog is no longer looked at once the start bit is in
                if (frame.rx_done) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Sent index is kept to compare against the response index
    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            sent_index <= i_req.index;
        end
    end

endmodule

// ==== verilog/sdcmd_shifter.sv ====
`timescale 1ns/1ps

module sdcmd_shifter (
    input  logic           i_clk,
    input  logic           i_nrst,
    input  logic           i_tick_fall,
    input  logic           i_tick_rise,
    input  logic           i_cmd,
    output logic           o_cmd,
    output logic           o_cmd_oe,
    sdcmd_frame_if.shifter frame
);

    localparam int FB    = sdcmd_cfg_pkg::FRAME_BITS;
    localparam int CNT_W = $clog2(FB + 1);
    // CRC covers the first FB-8 bits, then seven CRC bits and the end bit follow
    localparam logic [CNT_W-1:0] CRC_FIRST = CNT_W'(FB - 8);
    localparam logic [CNT_W-1:0] END_POS   = CNT_W'(FB - 1);
    localparam logic [CNT_W-1:0] TX_LAST   = CNT_W'(FB);

    logic [FB-1:0]    sreg;
    logic [FB-1:0]    rx_frame;
    logic [6:0]       crc;
    logic [CNT_W-1:0] cnt;
    logic             tx_active;
    logic             rx_active;
    logic             tx_step;
    logic             rx_begin;
    logic             rx_step;
    logic             tx_bit;

    // Serial CRC7 with polynomial x^7 + x^3 + 1
    function automatic logic [6:0] crc7_next(input logic [6:0] c, input logic b);
        logic fb;
        fb = b ^ c[6];
        return {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    endfunction

    assign tx_step  = tx_active && i_tick_fall;
    // The card pulls CMD low for its start bit
    assign rx_begin = frame.rx_arm && !rx_active && !tx_active && i_tick_rise && !i_cmd;
    assign rx_step  = rx_active && i_tick_rise;
    assign rx_frame = {sreg[FB-2:0], i_cmd};
    // CRC bits replace the zero placeholders loaded into the shift register
    assign tx_bit   = (cnt >= CRC_FIRST && cnt < END_POS) ? crc[6] : sreg[FB-1];

    // Shift register, CRC and response fields
    always_ff @(posedge i_clk) begin
        if (frame.tx_start) begin
            sreg <= {1'b0, 1'b1, frame.tx_index, frame.tx_arg, 7'h00, 1'b1};
            crc  <= '0;
        end else if (tx_step && cnt != TX_LAST) begin
            sreg <= {sreg[FB-2:0], 1'b0};
            crc  <= (cnt < CRC_FIRST) ? crc7_next(crc, sreg[FB-1]) : {crc[5:0], 1'b0};
        end else if (rx_begin) begin
            // Start bit is zero, so it leaves the CRC at zero
            sreg <= '0;
            crc  <= '0;
        end else if (rx_step) begin
            sreg <= rx_frame;
            if (cnt < CRC_FIRST) begin
                crc <= crc7_next(crc, i_cmd);
            end
        end
        if (rx_step && cnt == END_POS) begin
            frame.rx_index  <= rx_frame[FB-3 -: 6];
            frame.rx_arg    <= rx_frame[FB-9 -: 32];
            frame.rx_crc_ok <= (rx_frame[7:1] == crc);
            frame.rx_end_ok <= rx_frame[0];
        end
    end

    // Bit counter, line drivers and handshake pulses
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            tx_active        <= 1'b0;
            rx_active        <= 1'b0;
            cnt              <= '0;
            o_cmd            <= 1'b1;
            o_cmd_oe         <= 1'b0;
            frame.tx_done    <= 1'b0;
            frame.rx_started <= 1'b0;
            frame.rx_done    <= 1'b0;
        end else begin
            frame.tx_done    <= 1'b0;
            frame.rx_started <= 1'b0;
            frame.rx_done    <= 1'b0;
            if (frame.tx_start) begin
                tx_active <= 1'b1;
                cnt       <= '0;
            end else if (tx_step) begin
                if (cnt == TX_LAST) begin
                    // End bit has been on the line for a full SD clock
                    tx_active     <= 1'b0;
                    o_cmd         <= 1'b1;
                    o_cmd_oe      <= 1'b0;
                    frame.tx_done <= 1'b1;
                end else begin
                    o_cmd    <= tx_bit;
                    o_cmd_oe <= 1'b1;
                    cnt      <= cnt + 1'b1;
                end
            end else if (rx_begin) begin
                rx_active        <= 1'b1;
                cnt              <= CNT_W'(1);
                frame.rx_started <= 1'b1;
            end else if (rx_step) begin
                cnt <= cnt + 1'b1;
                if (cnt == END_POS) begin
                    rx_active     <= 1'b0;
                    frame.rx_done <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/sdcmd_timer.sv ====
`timescale 1ns/1ps

module sdcmd_timer (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_wd_start,
    output logic o_sd_clk,
    output logic o_tick_fall,
    output logic o_tick_rise,
    output logic o_wd_expired
);

    localparam int HALF  = sdcmd_cfg_pkg::CLK_DIV / 2;
    localparam int DIV_W = $clog2(sdcmd_cfg_pkg::CLK_DIV);
    localparam int WD_W  = $clog2(sdcmd_cfg_pkg::NCR_MAX + 1);

    logic [DIV_W-1:0] div_cnt;
    logic [WD_W-1:0]  wd_cnt;
    logic             wd_run;

    // Strobes mark the system clock edge at which o_sd_clk changes
    assign o_tick_rise = (div_cnt == DIV_W'(HALF - 1));
    assign o_tick_fall = (div_cnt == DIV_W'(sdcmd_cfg_pkg::CLK_DIV - 1));

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            div_cnt  <= '0;
            o_sd_clk <= 1'b0;
        end else begin
            div_cnt <= o_tick_fall ? '0 : div_cnt + 1'b1;
            if (o_tick_rise) begin
                o_sd_clk <= 1'b1;
            end else if (o_tick_fall) begin
                o_sd_clk <= 1'b0;
            end
        end
    end

    // Watchdog counts SD clocks and parks once the limit is hit
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wd_cnt       <= '0;
            wd_run       <= 1'b0;
            o_wd_expired <= 1'b0;
        end else if (i_wd_start) begin
            wd_cnt       <= '0;
            wd_run       <= 1'b1;
            o_wd_expired <= 1'b0;
        end else if (wd_run && o_tick_rise) begin
            wd_cnt <= wd_cnt + 1'b1;
            if (wd_cnt == WD_W'(sdcmd_cfg_pkg::NCR_MAX - 1)) begin
                wd_run       <= 1'b0;
                o_wd_expired <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/sdcmd_req_queue.sv ====
`timescale 1ns/1ps

module sdcmd_req_queue (
    input  logic                      i_clk,
    input  logic                      i_nrst,
    input  logic                      i_push,
    input  sdcmd_cfg_pkg::sdcmd_req_t i_req,
    input  logic                      i_pop,
    output sdcmd_cfg_pkg::sdcmd_req_t o_req,
    output logic                      o_nonempty,
    output logic                      o_credit
);

    localparam int DEPTH = sdcmd_cfg_pkg::REQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

    sdcmd_cfg_pkg::sdcmd_req_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    // A pop on an empty queue is ignored and returns no credit
    assign do_pop     = i_pop && o_nonempty;
    assign o_nonempty = (count != '0);
    // The head entry is always presented, the fsm reads it in the pop cycle
    assign o_req      = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_req;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the fill level unchanged
            if (i_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (!i_push && do_pop) begin
                count <= count - 1'b1;
            end
            // Each freed entry goes back to the host as one credit
            o_credit <= do_pop;
        end
    end

endmodule

// ==== verilog/sdcmd_frame_if.sv ====
`timescale 1ns/1ps

interface sdcmd_frame_if;

    // Transmit request, index and argument are valid in the tx_start cycle
    logic        tx_start;
    logic [5:0]  tx_index;
    logic [31:0] tx_arg;
    logic        tx_done;

    // Receive side, the payload is valid in the rx_done cycle
    logic        rx_arm;
    logic        rx_started;
    logic        rx_done;
    logic [5:0]  rx_index;
    logic [31:0] rx_arg;
    logic        rx_crc_ok;
    logic        rx_end_ok;

    modport fsm (
        output tx_start, tx_index, tx_arg, rx_arm,
        input  tx_done, rx_started, rx_done, rx_index, rx_arg, rx_crc_ok, rx_end_ok
    );

    modport shifter (
        input  tx_start, tx_index, tx_arg, rx_arm,
        output tx_done, rx_started, rx_done, rx_index, rx_arg, rx_crc_ok, rx_end_ok
    );

endinterface

// ==== verilog/sdcmd_err_pkg.sv ====
package sdcmd_err_pkg;

    // Error codes of the command path, zero means no error is stored
    localparam logic [3:0] ERR_NONE    = 4'd0;
    localparam logic [3:0] ERR_TIMEOUT = 4'd1;
    localparam logic [3:0] ERR_CRC     = 4'd2;
    localparam logic [3:0] ERR_END_BIT = 4'd3;
    localparam logic [3:0] ERR_INDEX   = 4'd4;

    // Register set of the sticky error latch
    typedef struct packed {
        logic [3:0] code;
    } sdcmd_err_regs_t;

    localparam sdcmd_err_regs_t err_regs_reset = '{code: ERR_NONE};

endpackage

// ==== verilog/sdcmd_cfg_pkg.sv ====
package sdcmd_cfg_pkg;

    // Command and response frames have the same length on the CMD line
    localparam int FRAME_BITS = 48;

    // System clocks per SD clock period, kept even so both halves are equal
    localparam int CLK_DIV = 4;

    // Queue entries, which is also the number of credits the host starts with
    localparam int REQ_DEPTH = 2;

    // SD clocks allowed from the command end bit to the response start bit
    localparam int NCR_MAX = 64;

    // One queued command as the host hands it over
    typedef struct packed {
        // Command index, sent after the start and direction bits
        logic [5:0]  index;
        // Command argument, sent most significant bit first
        logic [31:0] arg;
    } sdcmd_req_t;

endpackage
